//--- rtl/fetch_frontend_consts.svh
`ifndef FETCH_FRONTEND_CONSTS_SVH
`define FETCH_FRONTEND_CONSTS_SVH

// instruction address and data widths
`define ADDR_W    16
`define LINE_W    64
`define INST_W    32

// direct-mapped cache geometry, 32 lines of 8 bytes
`define IDX_W     5
`define TAG_W     8

// memory transaction tag, 0 means not accepted
`define BUS_TAG_W 4

// fetch buffer slots
`define FB_DEPTH  8

// first fetch address out of reset
`define RESET_PC  16'h0000

`endif

//--- rtl/fetch_frontend_pkg.sv
`include "fetch_frontend_consts.svh"

package fetch_frontend_pkg;

  // memory bus command
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // miss handling states
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_DATA
  } icache_state_e;

  // names one cache line
  typedef struct packed {
    logic [`TAG_W-1:0] tag;
    logic [`IDX_W-1:0] idx;
  } line_addr_t;

  // line write into the cache
  typedef struct packed {
    logic               wr_en;
    line_addr_t         addr;
    logic [`LINE_W-1:0] data;
  } fill_t;

  // one buffered instruction
  typedef struct packed {
    logic [`ADDR_W-1:0] pc;
    logic [`INST_W-1:0] inst;
  } fetch_slot_t;

endpackage

//--- rtl/icache_mem.sv
`include "fetch_frontend_consts.svh"

module icache_mem
  import fetch_frontend_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  line_addr_t         rd_addr,
  input  fill_t              fill,
  output logic [`LINE_W-1:0] rd_data,
  output logic               hit
);

  localparam int LINES = 1 << `IDX_W;

  logic [`LINE_W-1:0] data_mem [LINES];
  logic [`TAG_W-1:0]  tag_mem  [LINES];
  logic [LINES-1:0]   valid_mem;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  assign rd_data = data_mem[rd_addr.idx];
  assign hit     = valid_mem[rd_addr.idx] &&
                   (tag_mem[rd_addr.idx] == rd_addr.tag);

  ////////////////////////////////////////
  // line fill
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_mem <= '0;
    end else if (fill.wr_en) begin
      valid_mem[fill.addr.idx] <= 1'b1;
    end
  end

  // tag and data written together with the valid bit
  always_ff @(posedge clock) begin
    if (fill.wr_en) begin
      data_mem[fill.addr.idx] <= fill.data;
      tag_mem[fill.addr.idx]  <= fill.addr.tag;
    end
  end

endmodule

//--- rtl/icache_ctrl.sv
`include "fetch_frontend_consts.svh"

module icache_ctrl
  import fetch_frontend_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  line_addr_t            fetch_line,
  input  logic                  fetch_req,
  input  logic                  hit,
  input  logic [`BUS_TAG_W-1:0] mem2proc_response,
  input  logic [`BUS_TAG_W-1:0] mem2proc_tag,
  input  logic [`LINE_W-1:0]    mem2proc_data,
  output bus_cmd_e              proc2mem_command,
  output logic [`ADDR_W-1:0]    proc2mem_addr,
  output fill_t                 fill
);

  // byte offset bits inside a line
  localparam int OFF_W = `ADDR_W - `TAG_W - `IDX_W;

  icache_state_e         state;
  icache_state_e         state_next;
  line_addr_t            miss_line;
  logic [`BUS_TAG_W-1:0] pending_tag;
  logic                  start_miss;
  logic                  accepted;
  logic                  tag_match;

  assign start_miss = (state == IDLE) && fetch_req && !hit;
  assign accepted   = (state == REQUEST) && (mem2proc_response != '0);
  assign tag_match  = (state == WAIT_DATA) && (mem2proc_tag == pending_tag);

  ////////////////////////////////////////
  // miss FSM
  ////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start_miss) begin
          state_next = REQUEST;
        end
      end
      REQUEST: begin
        if (accepted) begin
          state_next = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (tag_match) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= IDLE;
      pending_tag <= '0;
    end else begin
      state <= state_next;
      if (accepted) begin
        pending_tag <= mem2proc_response;
      end
    end
  end

  // missing line held until its fill
  always_ff @(posedge clock) begin
    if (start_miss) begin
      miss_line <= fetch_line;
    end
  end

  ////////////////////////////////////////
  // bus request and fill
  ////////////////////////////////////////

  assign proc2mem_command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = (state == REQUEST) ? {miss_line, {OFF_W{1'b0}}} : '0;

  // write the line at the edge where the tag comes back
  assign fill.wr_en = tag_match;
  assign fill.addr  = miss_line;
  assign fill.data  = mem2proc_data;

endmodule

//--- rtl/fetch_stage.sv
`include "fetch_frontend_consts.svh"

module fetch_stage
  import fetch_frontend_pkg::*;
(
  input  logic                clock,
  input  logic                reset,
  input  logic                redirect,
  input  logic [`ADDR_W-1:0]  redirect_pc,
  input  logic                room,
  input  logic                hit,
  input  logic [`LINE_W-1:0]  line_data,
  output line_addr_t          fetch_line,
  output logic                fetch_req,
  output fetch_slot_t [1:0]   wr_slots,
  output logic [1:0]          wr_count
);

  localparam int OFF_W = `ADDR_W - `TAG_W - `IDX_W;
  localparam logic [`ADDR_W-1:0] INST_BYTES = `ADDR_W'(`INST_W / 8);
  localparam logic [`ADDR_W-1:0] LINE_BYTES = `ADDR_W'(`LINE_W / 8);

  logic [`ADDR_W-1:0] pc;
  logic [`ADDR_W-1:0] line_base;
  logic               upper_only;
  logic               fire;

  assign line_base  = {pc[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign upper_only = pc[OFF_W-1];
  assign fetch_line = line_addr_t'(pc[`ADDR_W-1:OFF_W]);

  // no lookup on the old path while redirecting
  assign fetch_req = room && !redirect;
  assign fire      = fetch_req && hit;

  ////////////////////////////////////////
  // instruction select
  ////////////////////////////////////////

  always_comb begin
    wr_slots[1].pc   = line_base + INST_BYTES;
    wr_slots[1].inst = line_data[`LINE_W-1:`INST_W];
    if (upper_only) begin
      wr_slots[0] = wr_slots[1];
    end else begin
      wr_slots[0].pc   = line_base;
      wr_slots[0].inst = line_data[`INST_W-1:0];
    end
    wr_count = fire ? (upper_only ? 2'd1 : 2'd2) : 2'd0;
  end

  // always predicts the next sequential line
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (fire) begin
      pc <= line_base + LINE_BYTES;
    end
  end

endmodule

//--- rtl/fetch_buffer_ptrs.sv
`include "fetch_frontend_consts.svh"

module fetch_buffer_ptrs (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         flush,
  input  logic                         pop,
  input  logic [1:0]                   push_count,
  output logic [$clog2(`FB_DEPTH)-1:0] head,
  output logic [$clog2(`FB_DEPTH)-1:0] tail,
  output logic                         room,
  output logic                         not_empty
);

  localparam int PTR_W = $clog2(`FB_DEPTH);

  logic [PTR_W:0] count;

  // pointer advance modulo depth
  function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] ptr,
                                                input logic [1:0]       inc);
    logic [PTR_W:0] sum;
    sum = (PTR_W+1)'(ptr) + (PTR_W+1)'(inc);
    if (sum >= (PTR_W+1)'(`FB_DEPTH)) begin
      sum = sum - (PTR_W+1)'(`FB_DEPTH);
    end
    return sum[PTR_W-1:0];
  endfunction

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= wrap_add(head, {1'b0, pop});
      tail  <= wrap_add(tail, push_count);
      count <= count + (PTR_W+1)'(push_count) - (PTR_W+1)'(pop);
    end
  end

  // room means two free slots, the most one fetch can write
  assign room      = (count <= (PTR_W+1)'(`FB_DEPTH - 2));
  assign not_empty = (count != '0);

endmodule

//--- rtl/fetch_buffer.sv
`include "fetch_frontend_consts.svh"

module fetch_buffer
  import fetch_frontend_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              redirect,
  input  logic              dispatch,
  input  fetch_slot_t [1:0] wr_slots,
  input  logic [1:0]        wr_count,
  output logic              room,
  output fetch_slot_t       inst_out,
  output logic              inst_valid
);

  localparam int PTR_W = $clog2(`FB_DEPTH);

  fetch_slot_t      slots [`FB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] tail_plus1;
  logic             not_empty;
  logic             pop;

  assign tail_plus1 = (tail == PTR_W'(`FB_DEPTH - 1)) ? '0 : tail + 1'b1;

  // dispatch on an empty buffer is ignored
  assign pop = dispatch && not_empty;

  fetch_buffer_ptrs i_fetch_buffer_ptrs (
    .clock      (clock),
    .reset      (reset),
    .flush      (redirect),
    .pop        (pop),
    .push_count (wr_count),
    .head       (head),
    .tail       (tail),
    .room       (room),
    .not_empty  (not_empty)
  );

  // slot writes dropped on redirect
  always_ff @(posedge clock) begin
    if (!redirect) begin
      if (wr_count != 2'd0) begin
        slots[tail] <= wr_slots[0];
      end
      if (wr_count == 2'd2) begin
        slots[tail_plus1] <= wr_slots[1];
      end
    end
  end

  assign inst_out   = slots[head];
  assign inst_valid = not_empty;

endmodule

//--- rtl/fetch_frontend.sv
`include "fetch_frontend_consts.svh"

module fetch_frontend
  import fetch_frontend_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic [`BUS_TAG_W-1:0] mem2proc_response,
  input  logic [`BUS_TAG_W-1:0] mem2proc_tag,
  input  logic [`LINE_W-1:0]    mem2proc_data,
  input  logic                  redirect,
  input  logic [`ADDR_W-1:0]    redirect_pc,
  input  logic                  dispatch,
  output bus_cmd_e              proc2mem_command,
  output logic [`ADDR_W-1:0]    proc2mem_addr,
  output fetch_slot_t           inst_out,
  output logic                  inst_valid
);

  line_addr_t         fetch_line;
  logic               fetch_req;
  logic               hit;
  logic [`LINE_W-1:0] line_data;
  fill_t              fill;
  logic               room;
  fetch_slot_t [1:0]  wr_slots;
  logic [1:0]         wr_count;

  ////////////////////////////////////////
  // instruction cache
  ////////////////////////////////////////

  icache_mem i_icache_mem (
    .clock   (clock),
    .reset   (reset),
    .rd_addr (fetch_line),
    .fill    (fill),
    .rd_data (line_data),
    .hit     (hit)
  );

  icache_ctrl i_icache_ctrl (
    .clock             (clock),
    .reset             (reset),
    .fetch_line        (fetch_line),
    .fetch_req         (fetch_req),
    .hit               (hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .fill              (fill)
  );

  ////////////////////////////////////////
  // fetch and queue
  ////////////////////////////////////////

  fetch_stage i_fetch_stage (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .room        (room),
    .hit         (hit),
    .line_data   (line_data),
    .fetch_line  (fetch_line),
    .fetch_req   (fetch_req),
    .wr_slots    (wr_slots),
    .wr_count    (wr_count)
  );

  fetch_buffer i_fetch_buffer (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .dispatch   (dispatch),
    .wr_slots   (wr_slots),
    .wr_count   (wr_count),
    .room       (room),
    .inst_out   (inst_out),
    .inst_valid (inst_valid)
  );

endmodule

//--- verif/fetch_frontend_checker.sv
`include "fetch_frontend_consts.svh"

module fetch_frontend_checker
  import fetch_frontend_pkg::*;
(
  input logic                  clock,
  input logic                  reset,
  input bus_cmd_e              proc2mem_command,
  input logic [`ADDR_W-1:0]    proc2mem_addr,
  input logic [`BUS_TAG_W-1:0] mem2proc_response,
  input logic                  redirect,
  input logic                  inst_valid
);

  localparam int OFF_W = `ADDR_W - `TAG_W - `IDX_W;

  // read by the testbench at the end of the run
  int unsigned assert_failures = 0;

  ////////////////////////////////////////
  // memory bus
  ////////////////////////////////////////

  a_no_store: assert property (@(posedge clock) disable iff (reset)
    proc2mem_command != BUS_STORE)
  else begin
    $error("store command on an instruction-only bus");
    assert_failures++;
  end

  a_line_aligned: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == BUS_LOAD) |-> (proc2mem_addr[OFF_W-1:0] == '0))
  else begin
    $error("load address %h not line aligned", proc2mem_addr);
    assert_failures++;
  end

  // request held until the memory accepts it
  a_request_hold: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == BUS_LOAD && mem2proc_response == '0) |=>
      (proc2mem_command == BUS_LOAD && $stable(proc2mem_addr)))
  else begin
    $error("load request dropped or changed before acceptance");
    assert_failures++;
  end

  ////////////////////////////////////////
  // dispatch port
  ////////////////////////////////////////

  a_redirect_empty: assert property (@(posedge clock) disable iff (reset)
    redirect |=> !inst_valid)
  else begin
    $error("instruction offered right after a redirect");
    assert_failures++;
  end

endmodule

bind fetch_frontend fetch_frontend_checker i_fetch_frontend_checker (
  .clock             (clock),
  .reset             (reset),
  .proc2mem_command  (proc2mem_command),
  .proc2mem_addr     (proc2mem_addr),
  .mem2proc_response (mem2proc_response),
  .redirect          (redirect),
  .inst_valid        (inst_valid)
);

//--- verif/fetch_frontend_tb.sv
`include "fetch_frontend_consts.svh"

module fetch_frontend_tb
  import fetch_frontend_pkg::*;
;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 40;
  // worst case for one instruction when its line misses behind another fill
  localparam int MISS_CYCLES  = 12;
  localparam int TOTAL_INSTS  = 24 + 24 + 16 + 32 + 16;
  localparam int WATCHDOG_CYCLES =
    2 * (TOTAL_INSTS * MISS_CYCLES + IDLE_CYCLES + RESET_CYCLES + 64);
  localparam logic [31:0] RAND_SEED = 32'h1571_b5bc;

  logic                  clock = 1'b0;
  logic                  reset;
  logic [`BUS_TAG_W-1:0] mem2proc_response;
  logic [`BUS_TAG_W-1:0] mem2proc_tag;
  logic [`LINE_W-1:0]    mem2proc_data;
  logic                  redirect;
  logic [`ADDR_W-1:0]    redirect_pc;
  logic                  dispatch;
  bus_cmd_e              proc2mem_command;
  logic [`ADDR_W-1:0]    proc2mem_addr;
  fetch_slot_t           inst_out;
  logic                  inst_valid;

  int error_count  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int total_errors;

  fetch_frontend i_fetch_frontend (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  ////////////////////////////////////////
  // memory contents and expected values
  ////////////////////////////////////////

  // address in the low half, address xor a5c3 in the high half
  function automatic logic [`INST_W-1:0] mem_word(input logic [`ADDR_W-1:0] addr);
    return {addr ^ 16'ha5c3, addr};
  endfunction

  function automatic fetch_slot_t expected_slot(input logic [`ADDR_W-1:0] pc);
    fetch_slot_t slot;
    slot.pc   = pc;
    slot.inst = mem_word(pc);
    return slot;
  endfunction

  ////////////////////////////////////////
  // checks and reporting
  ////////////////////////////////////////

  task automatic compare_slot(input fetch_slot_t got, input fetch_slot_t exp,
                              input string what);
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s got pc %h inst %h, expected pc %h inst %h",
               $time, what, got.pc, got.inst, exp.pc, exp.inst);
    end
  endtask

  task automatic compare_cmd(input bus_cmd_e got, input bus_cmd_e exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s got %s, expected %s",
               $time, what, got.name(), exp.name());
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("failure at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
      $display("test %s: FAIL with %0d bad checks", name, error_count - errors_before);
    end else begin
      $display("test %s: pass", name);
    end
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  initial begin : memory_model
    logic [`BUS_TAG_W-1:0] next_tag;
    logic [`BUS_TAG_W-1:0] pend_tag;
    logic [`ADDR_W-1:0]    pend_addr;
    int unsigned           pend_wait;
    logic                  pend_active;
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    next_tag          = 1;
    pend_tag          = '0;
    pend_addr         = '0;
    pend_wait         = 0;
    pend_active       = 1'b0;
    void'($urandom(RAND_SEED));
    forever begin
      @(posedge clock);
      #1;
      mem2proc_response = '0;
      mem2proc_tag      = '0;
      mem2proc_data     = '0;
      if (pend_active) begin
        if (pend_wait > 1) begin
          pend_wait--;
        end else begin
          mem2proc_tag  = pend_tag;
          mem2proc_data = {mem_word(pend_addr + 16'd4), mem_word(pend_addr)};
          pend_active   = 1'b0;
        end
      end
      // accept in the same cycle, data 2 to 6 cycles later
      if (proc2mem_command == BUS_LOAD && !pend_active) begin
        mem2proc_response = next_tag;
        pend_tag          = next_tag;
        pend_addr         = proc2mem_addr;
        pend_wait         = 2 + ($urandom % 5);
        pend_active       = 1'b1;
        next_tag          = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic redirect_to(input logic [`ADDR_W-1:0] pc);
    dispatch    = 1'b0;
    redirect    = 1'b1;
    redirect_pc = pc;
    @(posedge clock);
    #1;
    redirect = 1'b0;
    if (inst_valid) begin
      report_failure("inst_valid high the cycle after a redirect");
    end
  endtask

  // dispatch n instructions and check each against the sequential path
  task automatic collect_check(input logic [`ADDR_W-1:0] start_pc, input int n,
                               input logic [`ADDR_W-1:0] hit_limit);
    logic [`ADDR_W-1:0] exp_pc;
    int                 received;
    int                 cycles;
    exp_pc   = start_pc;
    received = 0;
    cycles   = 0;
    while (received < n && cycles < n * MISS_CYCLES) begin
      // lines below hit_limit are cached, so no load may target them
      if (proc2mem_addr < hit_limit) begin
        compare_cmd(proc2mem_command, BUS_NONE, "load for a cached line");
      end
      if (inst_valid) begin
        compare_slot(inst_out, expected_slot(exp_pc), "dispatched slot");
        dispatch = 1'b1;
        exp_pc   = exp_pc + 16'd4;
        received++;
      end else begin
        dispatch = 1'b0;
      end
      @(posedge clock);
      #1;
      cycles++;
    end
    dispatch = 1'b0;
    if (received < n) begin
      report_failure($sformatf("only %0d of %0d instructions arrived", received, n));
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_sequential;
    int errors_before;
    errors_before = error_count;
    compare_cmd(proc2mem_command, BUS_NONE, "bus command after reset");
    if (inst_valid) begin
      report_failure("inst_valid high right after reset");
    end
    collect_check(`RESET_PC, 24, '0);
    finish_test("sequential_fetch", errors_before);
  endtask

  task automatic test_cache_hits;
    int errors_before;
    errors_before = error_count;
    redirect_to(16'h0000);
    collect_check(16'h0000, 24, 16'd96);
    finish_test("cache_hits", errors_before);
  endtask

  task automatic test_unaligned;
    int errors_before;
    errors_before = error_count;
    redirect_to(16'h0124);
    collect_check(16'h0124, 16, '0);
    finish_test("unaligned_redirect", errors_before);
  endtask

  task automatic test_backpressure;
    int errors_before;
    errors_before = error_count;
    redirect_to(16'h0200);
    repeat (IDLE_CYCLES) @(posedge clock);
    #1;
    if (!inst_valid) begin
      report_failure("buffer still empty after the stall");
    end
    collect_check(16'h0200, 32, '0);
    finish_test("back_pressure", errors_before);
  endtask

  task automatic test_redirect_miss;
    int errors_before;
    int waited;
    errors_before = error_count;
    waited        = 0;
    redirect_to(16'h0800);
    while (proc2mem_command != BUS_LOAD && waited < MISS_CYCLES) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (proc2mem_command != BUS_LOAD) begin
      report_failure("no load issued for the missing line");
    end
    // one more edge so the load is accepted and outstanding
    @(posedge clock);
    #1;
    redirect_to(16'h0c40);
    collect_check(16'h0c40, 16, '0);
    finish_test("redirect_during_miss", errors_before);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    dispatch    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    test_sequential();
    test_cache_hits();
    test_unaligned();
    test_backpressure();
    test_redirect_miss();
    total_errors = error_count +
                   i_fetch_frontend.i_fetch_frontend_checker.assert_failures;
    $display("summary: %0d tests, %0d failed, %0d bad checks, %0d assertion failures",
             tests_run, tests_failed, error_count,
             i_fetch_frontend.i_fetch_frontend_checker.assert_failures);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

//--- fetch_frontend.f
+incdir+rtl
rtl/fetch_frontend_pkg.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/fetch_stage.sv
rtl/fetch_buffer_ptrs.sv
rtl/fetch_buffer.sv
rtl/fetch_frontend.sv
verif/fetch_frontend_checker.sv
verif/fetch_frontend_tb.sv
